/* Bender.yml */
package:
  name: lsu

sources:
  - files:
      - source/lsu_pkg.sv
      - source/lsu_access_plan.sv
      - source/lsu_bus_sequencer.sv
      - source/lsu_load_align.sv
      - source/lsu_top.sv
  - target: test
    files:
      - verification/lsu_bus_model.sv
      - verification/lsu_tb.sv

/* sim.f */
source/lsu_pkg.sv
source/lsu_access_plan.sv
source/lsu_bus_sequencer.sv
source/lsu_load_align.sv
source/lsu_top.sv
verification/lsu_bus_model.sv
verification/lsu_tb.sv

/* source/lsu_access_plan.sv */
// ====================
// Access planner: word split, crossing check,
// lane-shifted store data and strobes for both beats
// ====================
`timescale 1ns/1ps

module lsu_access_plan
    import lsu_pkg::*;
(
    input  lsu_cmd_t     i_cmd,
    output access_plan_t o_plan
);

    // ====================
    // Address split
    // ====================
    logic [OFFSET_W-1:0]   w_offset;
    logic [XLEN-1:0]       w_addr_lo;
    logic [XLEN-1:0]       w_addr_hi;
    // Offset in bits, 0/8/16/24
    logic [4:0]            w_shift;
    logic                  w_crosses;
    logic [XLEN-1:0]       w_wdata_raw;
    logic [NB_LANES-1:0]   w_wstrb_raw;
    logic [2*XLEN-1:0]     w_data_span;
    logic [2*NB_LANES-1:0] w_strb_span;

    assign w_offset  = i_cmd.addr[OFFSET_W-1:0];
    assign w_addr_lo = {i_cmd.addr[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};
    // Next word up
    assign w_addr_hi = w_addr_lo + XLEN'(NB_LANES);
    assign w_shift   = {w_offset, 3'b000};

    // ====================
    // Crossing detect
    // ====================
    always_comb begin
        unique case (i_cmd.size)
            // Single byte always fits
            LS_BYTE, LS_BYTE_U: w_crosses = 1'b0;
            // Half spills only from the last lane
            LS_HALF, LS_HALF_U: w_crosses = (w_offset == 2'b11);
            LS_WORD:            w_crosses = (w_offset != 2'b00);
            default:            w_crosses = 1'b0;
        endcase
    end

    // ====================
    // Store lane formatting
    // ====================
    // Zero extend to access size, strobe follows the size
    always_comb begin
        unique case (i_cmd.size)
            LS_BYTE, LS_BYTE_U: begin
                w_wdata_raw = {24'd0, i_cmd.wdata[7:0]};
                w_wstrb_raw = 4'b0001;
            end
            LS_HALF, LS_HALF_U: begin
                w_wdata_raw = {16'd0, i_cmd.wdata[15:0]};
                w_wstrb_raw = 4'b0011;
            end
            default: begin
                w_wdata_raw = i_cmd.wdata;
                w_wstrb_raw = 4'b1111;
            end
        endcase
    end

    // Shift across two words, spill lands in the upper half
    assign w_data_span = {{XLEN{1'b0}}, w_wdata_raw} << w_shift;
    assign w_strb_span = {{NB_LANES{1'b0}}, w_wstrb_raw} << w_offset;

    // ====================
    // Plan output
    // ====================
    always_comb begin
        o_plan.crosses       = w_crosses;
        o_plan.offset        = w_offset;
        // Lower word, always issued
        o_plan.lo_beat.addr  = w_addr_lo;
        o_plan.lo_beat.we    = i_cmd.write;
        o_plan.lo_beat.wdata = w_data_span[XLEN-1:0];
        o_plan.lo_beat.wstrb = w_strb_span[NB_LANES-1:0];
        // Upper word, split accesses only
        o_plan.hi_beat.addr  = w_addr_hi;
        o_plan.hi_beat.we    = i_cmd.write;
        o_plan.hi_beat.wdata = w_data_span[2*XLEN-1:XLEN];
        o_plan.hi_beat.wstrb = w_strb_span[2*NB_LANES-1:NB_LANES];
    end

endmodule

/* source/lsu_bus_sequencer.sv */
// ====================
// Bus sequencer FSM: one or two beats per command,
// grant tracking, error accumulation, completion
// ====================
`timescale 1ns/1ps

module lsu_bus_sequencer
    import lsu_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  lsu_cmd_t     i_cmd,
    input  access_plan_t i_plan,
    input  bus_rsp_t     i_dbus_rsp,
    output logic         o_dbus_req,
    output bus_beat_t    o_dbus_beat,
    output logic         o_capture_lo,
    output logic         o_beat_hi,
    output logic         o_busy,
    output logic         o_err
);

    typedef enum logic [1:0] {
        LSU_IDLE,
        // Aligned or non-crossing access
        LSU_SINGLE,
        // Lower word of a crossing access
        LSU_SPLIT_LO,
        // Upper word of a crossing access
        LSU_SPLIT_HI
    } lsu_state_e;

    lsu_state_e r_state;
    lsu_state_e w_state_next;
    // Current request already granted, waiting on rvalid
    logic       r_granted;
    // Error seen on the lower beat
    logic       r_err_acc;
    logic       w_mem_op;
    // Last beat answered this cycle
    logic       w_done;

    assign w_mem_op = i_cmd.valid && (i_cmd.read || i_cmd.write);

    // ====================
    // Next state and request
    // ====================
    always_comb begin
        w_state_next = r_state;
        o_dbus_req   = 1'b0;
        o_capture_lo = 1'b0;
        w_done       = 1'b0;
        unique case (r_state)
            LSU_IDLE: begin
                // Request goes out in the same cycle as the command
                if (w_mem_op) begin
                    o_dbus_req   = 1'b1;
                    w_state_next = i_plan.crosses ? LSU_SPLIT_LO : LSU_SINGLE;
                end
            end
            LSU_SINGLE: begin
                o_dbus_req = !r_granted;
                if (i_dbus_rsp.rvalid) begin
                    w_state_next = LSU_IDLE;
                    w_done       = 1'b1;
                end
            end
            LSU_SPLIT_LO: begin
                o_dbus_req = !r_granted;
                // Aligner keeps the lower word
                if (i_dbus_rsp.rvalid) begin
                    w_state_next = LSU_SPLIT_HI;
                    o_capture_lo = 1'b1;
                end
            end
            LSU_SPLIT_HI: begin
                // Fresh request starts the cycle after lower rvalid
                o_dbus_req = !r_granted;
                if (i_dbus_rsp.rvalid) begin
                    w_state_next = LSU_IDLE;
                    w_done       = 1'b1;
                end
            end
            default: w_state_next = LSU_IDLE;
        endcase
    end

    // Beat select, plan is stable while the command is held
    assign o_dbus_beat = (r_state == LSU_SPLIT_HI) ? i_plan.hi_beat : i_plan.lo_beat;
    assign o_beat_hi   = (r_state == LSU_SPLIT_HI);

    // ====================
    // State, grant, error
    // ====================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state   <= LSU_IDLE;
            r_granted <= 1'b0;
            r_err_acc <= 1'b0;
        end else begin
            r_state <= w_state_next;
            // rvalid wins over grant, grant over state change
            if (i_dbus_rsp.rvalid) begin
                r_granted <= 1'b0;
            end else if (o_dbus_req && i_dbus_rsp.gnt) begin
                r_granted <= 1'b1;
            end else if (w_state_next != r_state) begin
                r_granted <= 1'b0;
            end
            // Cleared on the way back to idle
            if (w_state_next == LSU_IDLE) begin
                r_err_acc <= 1'b0;
            end else if (o_capture_lo && i_dbus_rsp.err) begin
                r_err_acc <= 1'b1;
            end
        end
    end

    // Busy drops in the completion cycle
    assign o_busy = w_mem_op && !w_done;
    assign o_err  = w_done && (r_err_acc || (i_dbus_rsp.rvalid && i_dbus_rsp.err));

    // ====================
    // Assertions
    // ====================
    // Pending request keeps its beat until the bus takes it
    a_beat_stable : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_dbus_req && !i_dbus_rsp.gnt) |=> (o_dbus_req && $stable(o_dbus_beat)))
        else $error("bus beat changed before grant");

    // No response without an outstanding beat
    a_no_idle_rvalid : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (r_state == LSU_IDLE) |-> !i_dbus_rsp.rvalid)
        else $error("rvalid received while idle");

    // Error only reported with a completing command
    a_err_on_done : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_err |-> (i_cmd.valid && !o_busy))
        else $error("o_err outside a completion cycle");

endmodule

/* source/lsu_load_align.sv */
// ====================
// Load aligner: lower-word capture, byte shift
// and sign or zero extension
// ====================
`timescale 1ns/1ps

module lsu_load_align
    import lsu_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  lsu_cmd_t        i_cmd,
    input  access_plan_t    i_plan,
    input  bus_rsp_t        i_dbus_rsp,
    input  logic            i_capture_lo,
    input  logic            i_beat_hi,
    output logic [XLEN-1:0] o_rdata
);

    // Lower word of a split load
    logic [XLEN-1:0]   r_lo_word;
    logic [2*XLEN-1:0] w_combined;
    logic [2*XLEN-1:0] w_shifted;
    logic [XLEN-1:0]   w_raw;
    logic [4:0]        w_shift;

    // ====================
    // Capture
    // ====================
    always_ff @(posedge i_clk) begin
        if (i_capture_lo) begin
            r_lo_word <= i_dbus_rsp.rdata;
        end
    end

    // ====================
    // Combine and shift
    // ====================
    // Upper beat: new word over the stored one
    // Otherwise the live word alone
    assign w_combined = i_beat_hi ? {i_dbus_rsp.rdata, r_lo_word}
                                  : {{XLEN{1'b0}}, i_dbus_rsp.rdata};
    assign w_shift    = {i_plan.offset, 3'b000};
    assign w_shifted  = w_combined >> w_shift;
    assign w_raw      = w_shifted[XLEN-1:0];

    // ====================
    // Extension
    // ====================
    always_comb begin
        unique case (i_cmd.size)
            LS_BYTE:   o_rdata = {{24{w_raw[7]}}, w_raw[7:0]};
            LS_BYTE_U: o_rdata = {24'd0, w_raw[7:0]};
            LS_HALF:   o_rdata = {{16{w_raw[15]}}, w_raw[15:0]};
            LS_HALF_U: o_rdata = {16'd0, w_raw[15:0]};
            LS_WORD:   o_rdata = w_raw;
            default:   o_rdata = w_raw;
        endcase
    end

    // ====================
    // Assertions
    // ====================
    // Capture only on crossing commands, upper beat follows next cycle
    a_capture_split : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_capture_lo |-> (i_cmd.valid && i_plan.crosses) ##1 i_beat_hi)
        else $error("lower-word capture outside a split access");

endmodule

/* source/lsu_pkg.sv */
// ====================
// Load/store unit shared widths, size enum
// and the command, bus and access-plan structs
// ====================
package lsu_pkg;

    // ====================
    // Widths
    // ====================
    // Data and address width
    localparam int XLEN     = 32;
    // Byte lanes in one bus word
    localparam int NB_LANES = XLEN / 8;
    // Byte offset inside a word
    localparam int OFFSET_W = $clog2(NB_LANES);

    // ====================
    // Access size
    // ====================
    // The _U variants zero extend on loads
    // Stores treat them like the signed twin
    typedef enum logic [2:0] {
        LS_BYTE   = 3'd0,
        LS_BYTE_U = 3'd1,
        LS_HALF   = 3'd2,
        LS_HALF_U = 3'd3,
        LS_WORD   = 3'd4
    } ls_size_e;

    // ====================
    // Structs
    // ====================
    // One command from the memory stage
    typedef struct packed {
        logic            valid;
        logic            read;
        logic            write;
        ls_size_e        size;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } lsu_cmd_t;

    // One word-aligned bus access
    typedef struct packed {
        logic [XLEN-1:0]     addr;
        logic                we;
        logic [XLEN-1:0]     wdata;
        logic [NB_LANES-1:0] wstrb;
    } bus_beat_t;

    // Bus response, rvalid also acknowledges writes
    typedef struct packed {
        logic            gnt;
        logic            rvalid;
        logic [XLEN-1:0] rdata;
        logic            err;
    } bus_rsp_t;

    // Both beats of an access, hi_beat only used when crossing
    typedef struct packed {
        logic                crosses;
        logic [OFFSET_W-1:0] offset;
        bus_beat_t           lo_beat;
        bus_beat_t           hi_beat;
    } access_plan_t;

endpackage

/* source/lsu_top.sv */
// ====================
// Load/store unit top: planner, bus sequencer
// and load aligner
// ====================
`timescale 1ns/1ps

module lsu_top
    import lsu_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,

    // Command from memory stage
    input  lsu_cmd_t        i_cmd,

    // Data bus
    output logic            o_dbus_req,
    output bus_beat_t       o_dbus_beat,
    input  bus_rsp_t        i_dbus_rsp,

    // Result, valid in the completion cycle
    output logic [XLEN-1:0] o_rdata,
    output logic            o_busy,
    output logic            o_err
);

    access_plan_t w_plan;
    // Lower rvalid of a split access
    logic         w_capture_lo;
    // Upper beat in progress
    logic         w_beat_hi;

    // ====================
    // Input side
    // ====================
    lsu_access_plan plan_i (
        .i_cmd  (i_cmd),
        .o_plan (w_plan)
    );

    // ====================
    // Bus sequencing
    // ====================
    lsu_bus_sequencer seq_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cmd        (i_cmd),
        .i_plan       (w_plan),
        .i_dbus_rsp   (i_dbus_rsp),
        .o_dbus_req   (o_dbus_req),
        .o_dbus_beat  (o_dbus_beat),
        .o_capture_lo (w_capture_lo),
        .o_beat_hi    (w_beat_hi),
        .o_busy       (o_busy),
        .o_err        (o_err)
    );

    // ====================
    // Output side
    // ====================
    lsu_load_align align_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cmd        (i_cmd),
        .i_plan       (w_plan),
        .i_dbus_rsp   (i_dbus_rsp),
        .i_capture_lo (w_capture_lo),
        .i_beat_hi    (w_beat_hi),
        .o_rdata      (o_rdata)
    );

endmodule

/* verification/lsu_bus_model.sv */
// ====================
// Data bus responder: 64-word memory, random grant and
// read-valid delays, error region and beat log
// ====================
`timescale 1ns/1ps

module lsu_bus_model
    import lsu_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_req,
    input  bus_beat_t i_beat,
    output bus_rsp_t  o_rsp
);

    localparam int WORDS     = 64;
    // Top four words answer with err
    localparam int ERR_FIRST = WORDS - 4;

    logic [XLEN-1:0]     mem [0:WORDS-1];
    logic [31:0]         rng;
    // Beat log, cleared by the testbench per command
    logic [XLEN-1:0]     log_addr  [0:7];
    logic [NB_LANES-1:0] log_strb  [0:7];
    logic                log_moved [0:7];
    int                  log_cnt;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic clear_log();
        log_cnt = 0;
    endtask

    // One beat, entered on the clock edge that first sees the request
    task automatic serve_beat();
        bus_beat_t beat;
        logic      moved;
        int        idx;
        int        lane;
        beat  = i_beat;
        moved = 1'b0;
        rng   = lcg_next(rng);
        // Hold off grant, request must stay put meanwhile
        repeat (rng[29:28]) begin
            @(posedge i_clk);
            if (!i_req || i_beat !== beat) moved = 1'b1;
        end
        @(negedge i_clk);
        o_rsp.gnt = 1'b1;
        @(posedge i_clk);
        if (!i_req || i_beat !== beat) moved = 1'b1;
        if (log_cnt < 8) begin
            log_addr[log_cnt]  = beat.addr;
            log_strb[log_cnt]  = beat.wstrb;
            log_moved[log_cnt] = moved;
        end
        log_cnt++;
        @(negedge i_clk);
        o_rsp.gnt = 1'b0;
        rng       = lcg_next(rng);
        repeat (rng[29:28]) @(negedge i_clk);
        // Address wraps inside the 256-byte space
        idx         = beat.addr[7:2];
        o_rsp.rdata = mem[idx];
        if (beat.we) begin
            for (lane = 0; lane < NB_LANES; lane++) begin
                if (beat.wstrb[lane]) mem[idx][8*lane +: 8] = beat.wdata[8*lane +: 8];
            end
        end
        // Error region still performs the access
        o_rsp.err    = (idx >= ERR_FIRST);
        o_rsp.rvalid = 1'b1;
        @(negedge i_clk);
        o_rsp.rvalid = 1'b0;
        o_rsp.err    = 1'b0;
    endtask

    // ====================
    // Fill and serve
    // ====================
    initial begin
        int w;
        o_rsp   = '0;
        log_cnt = 0;
        rng     = 32'he5dd44f6;
        for (w = 0; w < WORDS; w++) begin
            rng    = lcg_next(rng);
            mem[w] = rng;
        end
        forever begin
            @(posedge i_clk);
            if (i_rst_n && i_req) serve_beat();
        end
    end

endmodule

/* verification/lsu_tb.sv */
// ====================
// LSU testbench: clock, reset, directed and random commands,
// reference model, result checks, watchdog
// ====================
`timescale 1ns/1ps

module lsu_tb
    import lsu_pkg::*;
();

    localparam int N_DIRECTED     = 43;
    localparam int N_RANDOM       = 200;
    localparam int N_CMDS         = N_DIRECTED + N_RANDOM;
    localparam int TIMEOUT_CYCLES = N_CMDS * 20 + 10;

    // Expected outcome of one command
    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
        logic [2:0]  nbytes;
        logic [1:0]  nbeats;
        logic [31:0] addr0;
        logic [31:0] addr1;
        logic [3:0]  strb0;
        logic [3:0]  strb1;
    } expect_t;

    logic            clk = 1'b0;
    logic            rst_n;
    lsu_cmd_t        cmd;
    logic            dbus_req;
    bus_beat_t       dbus_beat;
    bus_rsp_t        dbus_rsp;
    logic [XLEN-1:0] rdata;
    logic            busy;
    logic            err;

    // Byte image of the bus memory
    logic [7:0]      shadow [0:255];
    logic [31:0]     rng;
    expect_t         expected;
    int              issued   = 0;
    int              done_cnt = 0;
    int              errors   = 0;
    int              checks   = 0;

    always #50 clk = ~clk;

    lsu_top dut_i (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_cmd       (cmd),
        .o_dbus_req  (dbus_req),
        .o_dbus_beat (dbus_beat),
        .i_dbus_rsp  (dbus_rsp),
        .o_rdata     (rdata),
        .o_busy      (busy),
        .o_err       (err)
    );

    lsu_bus_model bus_i (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_req   (dbus_req),
        .i_beat  (dbus_beat),
        .o_rsp   (dbus_rsp)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
        end
    endtask

    // ====================
    // Reference model
    // ====================
    function automatic expect_t ref_access(input lsu_cmd_t c);
        expect_t     e;
        logic [31:0] raw;
        logic [7:0]  idx;
        int          n;
        int          i;
        int          lane;
        e   = '0;
        raw = '0;
        case (c.size)
            LS_BYTE, LS_BYTE_U: n = 1;
            LS_HALF, LS_HALF_U: n = 2;
            default:            n = 4;
        endcase
        // Walk the touched bytes, lanes past 3 belong to the upper word
        for (i = 0; i < n; i++) begin
            idx             = c.addr[7:0] + 8'(i);
            raw[8*i +: 8]   = shadow[idx];
            lane            = c.addr[1:0] + i;
            if (lane < 4) e.strb0[lane] = 1'b1;
            else e.strb1[lane-4] = 1'b1;
        end
        e.nbytes = 3'(n);
        e.nbeats = (c.addr[1:0] + n > 4) ? 2'd2 : 2'd1;
        e.addr0  = {c.addr[31:2], 2'b00};
        e.addr1  = e.addr0 + 32'd4;
        case (c.size)
            LS_BYTE:   e.rdata = {{24{raw[7]}}, raw[7:0]};
            LS_BYTE_U: e.rdata = {24'd0, raw[7:0]};
            LS_HALF:   e.rdata = {{16{raw[15]}}, raw[15:0]};
            LS_HALF_U: e.rdata = {16'd0, raw[15:0]};
            default:   e.rdata = raw;
        endcase
        e.err = (e.addr0[7:2] >= 60) || (e.nbeats == 2 && e.addr1[7:2] >= 60);
        return e;
    endfunction

    // ====================
    // Completion checks
    // ====================
    always @(posedge clk) begin : compare_proc
        int i;
        if (rst_n && cmd.valid && !busy) begin
            compare_value("beat count", expected.nbeats, bus_i.log_cnt);
            compare_value("beat 0 addr", expected.addr0, bus_i.log_addr[0]);
            compare_value("beat 0 wstrb", expected.strb0, bus_i.log_strb[0]);
            compare_value("beat 0 moved", 0, bus_i.log_moved[0]);
            if (expected.nbeats == 2) begin
                compare_value("beat 1 addr", expected.addr1, bus_i.log_addr[1]);
                compare_value("beat 1 wstrb", expected.strb1, bus_i.log_strb[1]);
                compare_value("beat 1 moved", 0, bus_i.log_moved[1]);
            end
            if (cmd.read) compare_value("o_rdata", expected.rdata, rdata);
            compare_value("o_err", expected.err, err);
            // Stores land in the shadow after the check
            if (cmd.write) begin
                for (i = 0; i < expected.nbytes; i++) begin
                    shadow[8'(cmd.addr[7:0] + 8'(i))] = cmd.wdata[8*i +: 8];
                end
            end
            done_cnt++;
        end else if (rst_n) begin
            compare_value("o_err", 0, err);
        end
    end

    // Present one command and hold it until it completes
    task automatic run_command(input lsu_cmd_t c);
        @(negedge clk);
        bus_i.clear_log();
        expected = ref_access(c);
        cmd      = c;
        issued++;
        wait (done_cnt == issued);
    endtask

    // ====================
    // Stimulus
    // ====================
    initial begin
        lsu_cmd_t c;
        int       w;
        int       sz;
        int       off;
        int       k;
        rst_n = 1'b0;
        cmd   = '0;
        rng   = 32'he5dd44f6;
        // Same fill sequence as the bus memory
        for (w = 0; w < 64; w++) begin
            rng = lcg_next(rng);
            {shadow[4*w+3], shadow[4*w+2], shadow[4*w+1], shadow[4*w]} = rng;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        // Idle bus with no command
        repeat (5) begin
            @(posedge clk);
            compare_value("o_dbus_req", 0, dbus_req);
            compare_value("o_busy", 0, busy);
        end
        // Every size at every offset, store then load back
        for (sz = 0; sz < 5; sz++) begin
            for (off = 0; off < 4; off++) begin
                rng     = lcg_next(rng);
                c.valid = 1'b1;
                c.size  = ls_size_e'(3'(sz));
                c.addr  = {24'd0, rng[23:18], 2'(off)};
                rng     = lcg_next(rng);
                c.wdata = rng;
                c.write = 1'b1;
                c.read  = 1'b0;
                run_command(c);
                c.write = 1'b0;
                c.read  = 1'b1;
                run_command(c);
            end
        end
        // Error region through the lower beat, the upper beat and a single beat
        for (k = 0; k < 3; k++) begin
            c.valid = 1'b1;
            c.size  = (k == 2) ? LS_BYTE : LS_WORD;
            c.addr  = (k == 0) ? 32'h0000_00fe : ((k == 1) ? 32'h0000_00ee : 32'h0000_00f5);
            c.write = 1'b0;
            c.read  = 1'b1;
            run_command(c);
        end
        repeat (N_RANDOM) begin
            rng     = lcg_next(rng);
            c.valid = 1'b1;
            c.size  = ls_size_e'(3'(rng[15:8] % 5));
            c.addr  = {24'd0, rng[23:16]};
            c.write = rng[28];
            c.read  = !rng[28];
            rng     = lcg_next(rng);
            c.wdata = rng;
            run_command(c);
        end
        @(negedge clk);
        cmd = '0;
        repeat (3) @(posedge clk);
        $display("Summary: %0d commands, %0d checks, %0d errors", issued, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // ====================
    // Watchdog
    // ====================
    initial begin
        #(TIMEOUT_CYCLES * 100);
        $display("Timeout: run still busy after %0d cycles, %0d of %0d commands done",
                 TIMEOUT_CYCLES, done_cnt, N_CMDS);
        $display("Checks failed");
        $finish;
    end

endmodule
